// File: rtl/mips_consts.svh
`ifndef MIPS_CONSTS_SVH
`define MIPS_CONSTS_SVH

`define XLEN       32
`define REGS       32
`define REG_AW     5
`define RESET_PC   32'h0000_0000
`define IMEM_WORDS 64
`define DMEM_WORDS 64

// major opcodes
`define OP_RTYPE   6'h00
`define OP_J       6'h02
`define OP_BEQ     6'h04
`define OP_ADDIU   6'h09
`define OP_LUI     6'h0f
`define OP_LW      6'h23
`define OP_SW      6'h2b

// funct field, only meaningful under OP_RTYPE
`define FN_ADDU    6'h21
`define FN_SUBU    6'h23
`define FN_AND     6'h24
`define FN_OR      6'h25
`define FN_SLT     6'h2a

`endif

// File: rtl/mips_pkg.sv
`include "mips_consts.svh"

package mips_pkg;

    typedef struct packed {
        logic [5:0]         op;
        logic [`REG_AW-1:0] rs;
        logic [`REG_AW-1:0] rt;
        logic [`REG_AW-1:0] rd;
        logic [4:0]         sa;
        logic [5:0]         funct;
    } rFmt_s;

    typedef struct packed {
        logic [5:0]         op;
        logic [`REG_AW-1:0] rs;
        logic [`REG_AW-1:0] rt;
        logic [15:0]        imm16;
    } iFmt_s;

    typedef struct packed {
        logic [5:0]  op;
        logic [25:0] target26;
    } jFmt_s;

    // one fetched word, three ways to read it
    typedef union packed {
        rFmt_s rFmt;
        iFmt_s iFmt;
        jFmt_s jFmt;
    } instrWord_u;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,
        ALU_PASSB
    } aluOp_e;

    typedef struct packed {
        aluOp_e aluOp;
        logic   useImm;   // operand b from the immediate
        logic   regWrite;
        logic   memRead;
        logic   memWrite;
        logic   isBranch;
        logic   isJump;
        logic   dstIsRt;  // i-type writes rt instead of rd
    } ctrl_s;

    typedef struct packed {
        logic [`XLEN-1:0] pc;
        instrWord_u       instr;
        logic             valid;
    } ifId_s;

    typedef struct packed {
        logic [`XLEN-1:0]   pc;
        logic [`REG_AW-1:0] rs;
        logic [`REG_AW-1:0] rt;
        logic [`REG_AW-1:0] wnum;
        logic [`XLEN-1:0]   rsVal;
        logic [`XLEN-1:0]   rtVal;
        logic [`XLEN-1:0]   imm;
        ctrl_s              ctrl;
        logic               valid;
    } idEx_s;

    typedef struct packed {
        logic [`XLEN-1:0]   pc;
        logic [`REG_AW-1:0] wnum;
        logic [`XLEN-1:0]   aluRes;
        logic [`XLEN-1:0]   storeData;
        ctrl_s              ctrl;
        logic               valid;
    } exMem_s;

    typedef struct packed {
        logic [`XLEN-1:0]   pc;
        logic [`REG_AW-1:0] wnum;
        logic [`XLEN-1:0]   result;
        ctrl_s              ctrl;
        logic               valid;
    } memWb_s;

    typedef struct packed {
        logic [`XLEN-1:0] addr;
        logic [`XLEN-1:0] wdata;
        logic             write;
    } dmemReq_s;

endpackage

// File: rtl/mainDecoder.sv
`include "mips_consts.svh"

module mainDecoder (
    input  mips_pkg::instrWord_u instr_i,
    output mips_pkg::ctrl_s      ctrl_o,
    output logic [`XLEN-1:0]     imm_o
);
    import mips_pkg::*;

    logic [`XLEN-1:0] immSext;

    assign immSext = {{(`XLEN-16){instr_i.iFmt.imm16[15]}}, instr_i.iFmt.imm16};

    always_comb begin
        ctrl_o = '0;      // default is a nop with every enable off
        imm_o  = immSext;
        case (instr_i.rFmt.op)
            `OP_RTYPE: begin
                ctrl_o.regWrite = 1'b1;
                case (instr_i.rFmt.funct)
                    `FN_ADDU: ctrl_o.aluOp = ALU_ADD;
                    `FN_SUBU: ctrl_o.aluOp = ALU_SUB;
                    `FN_AND:  ctrl_o.aluOp = ALU_AND;
                    `FN_OR:   ctrl_o.aluOp = ALU_OR;
                    `FN_SLT:  ctrl_o.aluOp = ALU_SLT;
                    default:  ctrl_o.regWrite = 1'b0; // sll 0 and friends land here
                endcase
            end
            `OP_ADDIU: begin
                ctrl_o.useImm   = 1'b1;
                ctrl_o.regWrite = 1'b1;
                ctrl_o.dstIsRt  = 1'b1;
            end
            `OP_LUI: begin
                ctrl_o.aluOp    = ALU_PASSB;
                ctrl_o.useImm   = 1'b1;
                ctrl_o.regWrite = 1'b1;
                ctrl_o.dstIsRt  = 1'b1;
                imm_o           = {instr_i.iFmt.imm16, 16'h0000};
            end
            `OP_LW: begin
                ctrl_o.useImm   = 1'b1;
                ctrl_o.regWrite = 1'b1;
                ctrl_o.memRead  = 1'b1;
                ctrl_o.dstIsRt  = 1'b1;
            end
            `OP_SW: begin
                ctrl_o.useImm   = 1'b1;
                ctrl_o.memWrite = 1'b1;
            end
            `OP_BEQ: begin
                ctrl_o.aluOp    = ALU_SUB; // equal when the difference is zero
                ctrl_o.isBranch = 1'b1;
            end
            `OP_J:   ctrl_o.isJump = 1'b1;
            default: ctrl_o = '0;
        endcase
    end

endmodule

// File: rtl/regFile.sv
`include "mips_consts.svh"

module regFile (
    input  logic               clk,
    input  logic               rst_i,
    input  logic [`REG_AW-1:0] raddrA_i,
    input  logic [`REG_AW-1:0] raddrB_i,
    output logic [`XLEN-1:0]   rdataA_o,
    output logic [`XLEN-1:0]   rdataB_o,
    input  logic               we_i,
    input  logic [`REG_AW-1:0] waddr_i,
    input  logic [`XLEN-1:0]   wdata_i
);

    logic [`XLEN-1:0] regs [`REGS];
    logic             wrLive;

    assign wrLive = we_i && (waddr_i != '0); // r0 stays zero

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < `REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wrLive) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // writeback in this cycle is seen by decode right away
    assign rdataA_o = (wrLive && waddr_i == raddrA_i) ? wdata_i : regs[raddrA_i];
    assign rdataB_o = (wrLive && waddr_i == raddrB_i) ? wdata_i : regs[raddrB_i];

endmodule

// File: rtl/aluUnit.sv
`include "mips_consts.svh"

module aluUnit (
    input  mips_pkg::aluOp_e   op_i,
    input  logic [`XLEN-1:0]   a_i,
    input  logic [`XLEN-1:0]   b_i,
    output logic [`XLEN-1:0]   result_o,
    output logic               zero_o
);
    import mips_pkg::*;

    logic lessThan;

    assign lessThan = $signed(a_i) < $signed(b_i);

    always_comb begin
        case (op_i)
            ALU_ADD:   result_o = a_i + b_i;
            ALU_SUB:   result_o = a_i - b_i;
            ALU_AND:   result_o = a_i & b_i;
            ALU_OR:    result_o = a_i | b_i;
            ALU_SLT:   result_o = {{(`XLEN-1){1'b0}}, lessThan};
            ALU_PASSB: result_o = b_i;       // lui
            default:   result_o = '0;
        endcase
    end

    assign zero_o = (result_o == '0); // beq taken flag

endmodule

// File: rtl/hazardUnit.sv
`include "mips_consts.svh"

module hazardUnit (
    input  logic [`REG_AW-1:0] idRs_i,
    input  logic [`REG_AW-1:0] idRt_i,
    input  mips_pkg::idEx_s    ex_i,
    input  mips_pkg::exMem_s   mem_i,
    input  mips_pkg::memWb_s   wb_i,
    input  logic               branchTaken_i,
    input  logic               jumpD_i,
    input  logic               memWait_i,
    output logic [1:0]         fwdA_o,
    output logic [1:0]         fwdB_o,
    output logic               stallF_o,
    output logic               stallD_o,
    output logic               freeze_o,
    output logic               flushD_o,
    output logic               flushE_o
);
    import mips_pkg::*;

    logic loadUse;

    // MEM holds the younger result, so it is checked first
    function automatic logic [1:0] pickSrc(input logic [`REG_AW-1:0] src,
                                           input exMem_s m,
                                           input memWb_s w);
        if (m.valid && m.ctrl.regWrite && m.wnum != '0 && m.wnum == src) begin
            return 2'd1;
        end else if (w.valid && w.ctrl.regWrite && w.wnum != '0 && w.wnum == src) begin
            return 2'd2;
        end
        return 2'd0;
    endfunction

    assign fwdA_o = pickSrc(ex_i.rs, mem_i, wb_i);
    assign fwdB_o = pickSrc(ex_i.rt, mem_i, wb_i);

    // load data only exists at the end of MEM
    assign loadUse = ex_i.valid && ex_i.ctrl.memRead && ex_i.wnum != '0
                     && (ex_i.wnum == idRs_i || ex_i.wnum == idRt_i);

    assign stallF_o = loadUse | memWait_i;
    assign stallD_o = loadUse | memWait_i;
    assign freeze_o = memWait_i;

    // branch in EX beats the jump sitting behind it in decode
    assign flushD_o = ~memWait_i & (branchTaken_i | (jumpD_i & ~loadUse));
    assign flushE_o = ~memWait_i & (branchTaken_i | loadUse);

endmodule

// File: rtl/mipsDatapath.sv
`include "mips_consts.svh"

module mipsDatapath (
    input  logic                clk,
    input  logic                rst_i,
    output logic [`XLEN-1:0]    imemAddr_o,
    input  logic [`XLEN-1:0]    imemData_i,
    output mips_pkg::dmemReq_s  dmemReq_o,
    output logic                dmemValid_o,
    input  logic                dmemReady_i,
    input  logic [`XLEN-1:0]    dmemRdata_i,
    output logic                retireValid_o,
    output logic [`XLEN-1:0]    retirePc_o,
    output logic                retireWen_o,
    output logic [`REG_AW-1:0]  retireWnum_o,
    output logic [`XLEN-1:0]    retireWdata_o
);
    import mips_pkg::*;

    logic [`XLEN-1:0] pcF;
    logic [`XLEN-1:0] pcPlus4F;
    ifId_s            ifId;
    idEx_s            idEx;
    idEx_s            idExNext;
    exMem_s           exMem;
    exMem_s           exMemNext;
    memWb_s           memWb;
    memWb_s           memWbNext;

    ctrl_s            ctrlD;
    logic [`XLEN-1:0] immD;
    logic [`XLEN-1:0] rsValD;
    logic [`XLEN-1:0] rtValD;
    logic [`XLEN-1:0] pcPlus4D;
    logic [`XLEN-1:0] jumpTargetD;
    logic             jumpD;

    logic [`XLEN-1:0] srcA;
    logic [`XLEN-1:0] rtFwd;
    logic [`XLEN-1:0] srcB;
    logic [`XLEN-1:0] aluResE;
    logic [`XLEN-1:0] branchTarget;
    logic             zeroE;
    logic             branchTaken;

    logic [1:0]       fwdA;
    logic [1:0]       fwdB;
    logic             stallF;
    logic             stallD;
    logic             freeze;
    logic             flushD;
    logic             flushE;
    logic             memWait;
    logic             regWe;

    function automatic logic [`XLEN-1:0] fwdPick(input logic [1:0] sel,
                                                 input logic [`XLEN-1:0] regVal,
                                                 input logic [`XLEN-1:0] memVal,
                                                 input logic [`XLEN-1:0] wbVal);
        case (sel)
            2'd1:    return memVal;
            2'd2:    return wbVal;
            default: return regVal;
        endcase
    endfunction

    // fetch
    assign pcPlus4F   = pcF + 32'd4;
    assign imemAddr_o = pcF;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            pcF <= `RESET_PC;
        end else if (!freeze) begin
            if (branchTaken) begin
                pcF <= branchTarget;
            end else if (!stallF) begin
                pcF <= jumpD ? jumpTargetD : pcPlus4F;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            ifId.valid <= 1'b0;
        end else if (flushD) begin
            ifId.valid <= 1'b0; // wrong-path fetch
        end else if (!stallD) begin
            ifId.pc    <= pcF;
            ifId.instr <= imemData_i;
            ifId.valid <= 1'b1;
        end
    end

    // decode
    mainDecoder u_mainDecoder (
        .instr_i (ifId.instr),
        .ctrl_o  (ctrlD),
        .imm_o   (immD)
    );

    regFile u_regFile (
        .clk      (clk),
        .rst_i    (rst_i),
        .raddrA_i (ifId.instr.rFmt.rs),
        .raddrB_i (ifId.instr.rFmt.rt),
        .rdataA_o (rsValD),
        .rdataB_o (rtValD),
        .we_i     (regWe),
        .waddr_i  (memWb.wnum),
        .wdata_i  (memWb.result)
    );

    assign pcPlus4D    = ifId.pc + 32'd4;
    assign jumpTargetD = {pcPlus4D[31:28], ifId.instr.jFmt.target26, 2'b00};
    assign jumpD       = ifId.valid & ctrlD.isJump;

    always_comb begin
        idExNext.pc    = ifId.pc;
        idExNext.rs    = ifId.instr.rFmt.rs;
        idExNext.rt    = ifId.instr.rFmt.rt;
        idExNext.wnum  = ctrlD.dstIsRt ? ifId.instr.rFmt.rt : ifId.instr.rFmt.rd;
        idExNext.rsVal = rsValD;
        idExNext.rtVal = rtValD;
        idExNext.imm   = immD;
        idExNext.ctrl  = ctrlD;
        idExNext.valid = ifId.valid;
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            idEx.valid <= 1'b0;
        end else if (!freeze) begin
            if (flushE) begin
                idEx.valid <= 1'b0; // bubble for load-use or taken beq
            end else begin
                idEx <= idExNext;
            end
        end
    end

    // execute
    assign srcA  = fwdPick(fwdA, idEx.rsVal, exMem.aluRes, memWb.result);
    assign rtFwd = fwdPick(fwdB, idEx.rtVal, exMem.aluRes, memWb.result);
    assign srcB  = idEx.ctrl.useImm ? idEx.imm : rtFwd;

    aluUnit u_aluUnit (
        .op_i     (idEx.ctrl.aluOp),
        .a_i      (srcA),
        .b_i      (srcB),
        .result_o (aluResE),
        .zero_o   (zeroE)
    );

    assign branchTaken  = idEx.valid & idEx.ctrl.isBranch & zeroE;
    assign branchTarget = idEx.pc + 32'd4 + {idEx.imm[29:0], 2'b00};

    always_comb begin
        exMemNext.pc        = idEx.pc;
        exMemNext.wnum      = idEx.wnum;
        exMemNext.aluRes    = aluResE;
        exMemNext.storeData = rtFwd;
        exMemNext.ctrl      = idEx.ctrl;
        exMemNext.valid     = idEx.valid;
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            exMem.valid <= 1'b0;
        end else if (!freeze) begin
            exMem <= exMemNext;
        end
    end

    // memory, request held steady by the freeze
    assign dmemReq_o   = '{addr: exMem.aluRes, wdata: exMem.storeData,
                           write: exMem.ctrl.memWrite};
    assign dmemValid_o = exMem.valid & (exMem.ctrl.memRead | exMem.ctrl.memWrite);
    assign memWait     = dmemValid_o & ~dmemReady_i;

    always_comb begin
        memWbNext.pc     = exMem.pc;
        memWbNext.wnum   = exMem.wnum;
        memWbNext.result = exMem.ctrl.memRead ? dmemRdata_i : exMem.aluRes;
        memWbNext.ctrl   = exMem.ctrl;
        memWbNext.valid  = exMem.valid;
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            memWb.valid <= 1'b0;
        end else if (!freeze) begin
            memWb <= memWbNext;
        end
    end

    hazardUnit u_hazardUnit (
        .idRs_i        (ifId.instr.rFmt.rs),
        .idRt_i        (ifId.instr.rFmt.rt),
        .ex_i          (idEx),
        .mem_i         (exMem),
        .wb_i          (memWb),
        .branchTaken_i (branchTaken),
        .jumpD_i       (jumpD),
        .memWait_i     (memWait),
        .fwdA_o        (fwdA),
        .fwdB_o        (fwdB),
        .stallF_o      (stallF),
        .stallD_o      (stallD),
        .freeze_o      (freeze),
        .flushD_o      (flushD),
        .flushE_o      (flushE)
    );

    // writeback, counted once when the pipe moves on
    assign regWe         = memWb.valid & memWb.ctrl.regWrite & ~freeze;
    assign retireValid_o = memWb.valid & ~freeze;
    assign retirePc_o    = memWb.pc;
    assign retireWen_o   = regWe;
    assign retireWnum_o  = memWb.wnum;
    assign retireWdata_o = memWb.result;

endmodule

// File: bench/clkGen.sv
module clkGen (
    output logic clk_o,
    output logic rst_o
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk_o = 1'b0;
        forever #20 clk_o = ~clk_o; // 40 ns period
    end

    initial begin
        rst_o = 1'b1;
        repeat (2) @(posedge clk_o);
        rst_o <= 1'b0;
    end

endmodule

// File: bench/core_sva.sv
`include "mips_consts.svh"

module core_sva (
    input logic               clk,
    input logic               rst_i,
    input logic               retireValid_i,
    input logic [`XLEN-1:0]   retirePc_i,
    input logic               retireWen_i,
    input logic [`REG_AW-1:0] retireWnum_i,
    input logic [`XLEN-1:0]   retireWdata_i,
    input mips_pkg::dmemReq_s dmemReq_i,
    input logic               dmemValid_i,
    input logic               dmemReady_i
);
    timeunit 1ns;
    timeprecision 1ps;
    import mips_pkg::*;

    logic [`XLEN-1:0]   progMem [`IMEM_WORDS];
    logic [`XLEN-1:0]   gRegs [`REGS];
    logic [`XLEN-1:0]   gMem [`DMEM_WORDS];
    logic [`XLEN-1:0]   gPc;
    logic               retiredAny;
    int                 errCount = 0;

    instrWord_u         ins;
    logic [`XLEN-1:0]   rsV;
    logic [`XLEN-1:0]   rtV;
    logic [`XLEN-1:0]   simm;
    logic [`XLEN-1:0]   effAddr;
    logic [`XLEN-1:0]   seqPc;
    logic [`XLEN-1:0]   nextPc;
    logic               expWen;
    logic [`REG_AW-1:0] expWnum;
    logic [`XLEN-1:0]   expWdata;
    logic               storeNow;

    task automatic noteMismatch(input string field);
        errCount = errCount + 1;
        $error("MISMATCH %0t %s differs from the golden model", $time, field);
    endtask

    task automatic protocolFault(input string what);
        errCount = errCount + 1;
        $error("%s at %0t", what, $time);
    endtask

    initial begin
        for (int i = 0; i < `IMEM_WORDS; i++) begin
            progMem[i] = '0;
        end
        $readmemh("bench/program.hex", progMem);
    end

    // one ISA step for the instruction at gPc
    always_comb begin
        ins      = progMem[gPc[7:2]];
        rsV      = gRegs[ins.rFmt.rs];
        rtV      = gRegs[ins.rFmt.rt];
        simm     = {{16{ins.iFmt.imm16[15]}}, ins.iFmt.imm16};
        effAddr  = rsV + simm;
        seqPc    = gPc + 32'd4;
        nextPc   = seqPc;
        expWen   = 1'b0;
        expWnum  = ins.iFmt.rt;
        expWdata = '0;
        storeNow = 1'b0;
        case (ins.rFmt.op)
            `OP_RTYPE: begin
                expWen  = 1'b1;
                expWnum = ins.rFmt.rd;
                case (ins.rFmt.funct)
                    `FN_ADDU: expWdata = rsV + rtV;
                    `FN_SUBU: expWdata = rsV - rtV;
                    `FN_AND:  expWdata = rsV & rtV;
                    `FN_OR:   expWdata = rsV | rtV;
                    `FN_SLT:  expWdata = {31'b0, $signed(rsV) < $signed(rtV)};
                    default:  expWen = 1'b0;
                endcase
            end
            `OP_ADDIU: begin
                expWen   = 1'b1;
                expWdata = rsV + simm;
            end
            `OP_LUI: begin
                expWen   = 1'b1;
                expWdata = {ins.iFmt.imm16, 16'h0000};
            end
            `OP_LW: begin
                expWen   = 1'b1;
                expWdata = gMem[effAddr[7:2]];
            end
            `OP_SW:  storeNow = 1'b1;
            `OP_BEQ: begin
                if (rsV == rtV) begin
                    nextPc = seqPc + {simm[29:0], 2'b00};
                end
            end
            `OP_J:   nextPc = {seqPc[31:28], ins.jFmt.target26, 2'b00};
            default: ;
        endcase
    end

    always @(posedge clk) begin
        if (rst_i) begin
            gPc        <= `RESET_PC;
            retiredAny <= 1'b0;
            for (int i = 0; i < `REGS; i++) begin
                gRegs[i] <= '0;
            end
            for (int i = 0; i < `DMEM_WORDS; i++) begin
                gMem[i] <= 32'hDA7A_0000 | (i << 2); // same image as the bench memory
            end
        end else if (retireValid_i) begin
            gPc        <= nextPc;
            retiredAny <= 1'b1;
            if (expWen && expWnum != '0) begin
                gRegs[expWnum] <= expWdata;
            end
            if (storeNow) begin
                gMem[effAddr[7:2]] <= rtV;
            end
        end
    end

    pcMatch: assert property (@(posedge clk) disable iff (rst_i)
        retireValid_i |-> retirePc_i == gPc)
        else noteMismatch("retirePc_o");

    wenMatch: assert property (@(posedge clk) disable iff (rst_i)
        retireValid_i |-> retireWen_i == expWen)
        else noteMismatch("retireWen_o");

    wnumMatch: assert property (@(posedge clk) disable iff (rst_i)
        retireValid_i && expWen |-> retireWnum_i == expWnum)
        else noteMismatch("retireWnum_o");

    wdataMatch: assert property (@(posedge clk) disable iff (rst_i)
        retireValid_i && expWen |-> retireWdata_i == expWdata)
        else noteMismatch("retireWdata_o");

    reqHeld: assert property (@(posedge clk) disable iff (rst_i)
        dmemValid_i && !dmemReady_i |=> dmemValid_i && $stable(dmemReq_i))
        else protocolFault("data request changed or dropped while ready was low");

    quietBeforeRetire: assert property (@(posedge clk) disable iff (rst_i)
        !retiredAny |-> !dmemValid_i)
        else protocolFault("data request seen before the first retirement");

endmodule

// File: bench/coreTb.sv
`include "mips_consts.svh"

module coreTb;
    timeunit 1ns;
    timeprecision 1ps;
    import mips_pkg::*;

    localparam logic [`XLEN-1:0] DONE_PC = 32'h0000_0064; // self-jump at the end of the program
    localparam int MAX_RETIRES = 60;
    localparam int MEM_OPS     = 8;
    localparam int MAX_WAIT    = 32;  // generous run of ready low per access
    localparam int CLK_PERIOD  = 40;
    localparam int WATCHDOG_CYCLES = 2 + MAX_RETIRES * 4 + MEM_OPS * MAX_WAIT;

    logic               clk;
    logic               rst;
    logic [`XLEN-1:0]   imemAddr;
    logic [`XLEN-1:0]   imemData;
    dmemReq_s           dmemReq;
    logic               dmemValid;
    logic               dmemReady = 1'b0;
    logic [`XLEN-1:0]   dmemRdata;
    logic               retireValid;
    logic [`XLEN-1:0]   retirePc;
    logic               retireWen;
    logic [`REG_AW-1:0] retireWnum;
    logic [`XLEN-1:0]   retireWdata;

    logic [`XLEN-1:0]   rom [`IMEM_WORDS];
    logic [`XLEN-1:0]   dmem [`DMEM_WORDS];
    logic [31:0]        rngState = 32'd1302;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    clkGen u_clkGen (
        .clk_o (clk),
        .rst_o (rst)
    );

    mipsDatapath u_mipsDatapath (
        .clk           (clk),
        .rst_i         (rst),
        .imemAddr_o    (imemAddr),
        .imemData_i    (imemData),
        .dmemReq_o     (dmemReq),
        .dmemValid_o   (dmemValid),
        .dmemReady_i   (dmemReady),
        .dmemRdata_i   (dmemRdata),
        .retireValid_o (retireValid),
        .retirePc_o    (retirePc),
        .retireWen_o   (retireWen),
        .retireWnum_o  (retireWnum),
        .retireWdata_o (retireWdata)
    );

    bind mipsDatapath core_sva u_coreSva (
        .clk           (clk),
        .rst_i         (rst_i),
        .retireValid_i (retireValid_o),
        .retirePc_i    (retirePc_o),
        .retireWen_i   (retireWen_o),
        .retireWnum_i  (retireWnum_o),
        .retireWdata_i (retireWdata_o),
        .dmemReq_i     (dmemReq_o),
        .dmemValid_i   (dmemValid_o),
        .dmemReady_i   (dmemReady_i)
    );

    // instruction ROM answers in the same cycle
    assign imemData  = rom[imemAddr[7:2]];
    assign dmemRdata = dmem[dmemReq.addr[7:2]];

    always @(posedge clk) begin
        if (rst) begin
            dmemReady <= 1'b0;
        end else begin
            rngState  <= xorshift32(rngState);
            dmemReady <= rngState[7];  // low about half the time
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `DMEM_WORDS; i++) begin
                dmem[i] <= 32'hDA7A_0000 | (i << 2);
            end
        end else if (dmemValid && dmemReady && dmemReq.write) begin
            dmem[dmemReq.addr[7:2]] <= dmemReq.wdata;
        end
    end

    initial begin
        for (int i = 0; i < `IMEM_WORDS; i++) begin
            rom[i] = '0;
        end
        $readmemh("bench/program.hex", rom);
        wait (rst === 1'b0);
        do begin
            @(posedge clk);
        end while (!(retireValid && retirePc == DONE_PC));
        @(posedge clk);  // last retirement checked by now
        if (u_mipsDatapath.u_coreSva.errCount != 0) begin
            $display("Test failures found");
            $fatal(1, "checker reported errors");
        end else begin
            $display("All tests passed!");
            $finish;
        end
    end

    initial begin
        wait (u_mipsDatapath.u_coreSva.errCount != 0);
        $display("Test failures found");
        $fatal(1, "run stopped at the first checker error");
    end

    // watchdog
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("program did not reach its final self-jump before the watchdog ran out");
        $display("Test failures found");
        $fatal(1, "watchdog timeout");
    end

endmodule

// File: bench/program.hex
// one 32-bit instruction word per line, hex, starting at byte address 0
// the program ends in a self-jump at 0x64
3C011234 // 00 lui   $1, 0x1234
24020010 // 04 addiu $2, $0, 16
24430005 // 08 addiu $3, $2, 5      fwd from MEM
00622021 // 0c addu  $4, $3, $2     fwd from MEM and WB
00812823 // 10 subu  $5, $4, $1
00233025 // 14 or    $6, $1, $3
00C43824 // 18 and   $7, $6, $4
00A2402A // 1c slt   $8, $5, $2     negative vs positive
AC460004 // 20 sw    $6, 4($2)
8C490004 // 24 lw    $9, 4($2)
01285021 // 28 addu  $10, $9, $8    load-use
AC4A0008 // 2c sw    $10, 8($2)
8C4B0008 // 30 lw    $11, 8($2)
116A0002 // 34 beq   $11, $10, +2   taken
240C0BAD // 38 addiu $12, $0, 0xbad wrong path
240D0BAD // 3c addiu $13, $0, 0xbad wrong path
10430001 // 40 beq   $2, $3, +1     not taken
240E0077 // 44 addiu $14, $0, 0x77
08000015 // 48 j     0x54
240F0BAD // 4c addiu $15, $0, 0xbad wrong path
24100BAD // 50 addiu $16, $0, 0xbad skipped
01CB8821 // 54 addu  $17, $14, $11
8C520004 // 58 lw    $18, 4($2)
AC52000C // 5c sw    $18, 12($2)    load-use on store data
8C53000C // 60 lw    $19, 12($2)
08000019 // 64 j     0x64           self-jump

// File: src.f
+incdir+rtl
rtl/mips_pkg.sv
rtl/mainDecoder.sv
rtl/regFile.sv
rtl/aluUnit.sv
rtl/hazardUnit.sv
rtl/mipsDatapath.sv
bench/clkGen.sv
bench/core_sva.sv
bench/coreTb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = coreTb
FILELIST  = src.f
OBJDIR    = obj_dir
SIMARGS   = +verilator+error+limit+100

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) $(SIMARGS) | tee /dev/stderr | grep -q "All tests passed!"

clean:
	rm -rf $(OBJDIR)
